/* source/cache_pkg.sv */
package cache_pkg;

	// ----------------------------------------------------------------------
	// Cache geometry
	// ----------------------------------------------------------------------

	// Two-way, 16 sets, eight words per line
	localparam int ways       = 2;
	localparam int sets       = 16;
	localparam int line_words = 8;

	// Data and address widths
	typedef logic [31:0] word_t;
	typedef logic [27:0] addr_t;

	// Word address split as tag | index | offset
	typedef logic [2:0]  offset_t;
	typedef logic [3:0]  index_t;
	typedef logic [20:0] tag_t;

	// Whole line, word 0 sits in the low bits
	typedef word_t [line_words-1:0] line_t;

	// Processor request as sampled by the controller
	typedef struct packed {
		logic  valid;
		logic  write;
		logic  flush;
		addr_t addr;
		word_t wdata;
	} cpu_req_t;

	// Controller FSM states
	typedef enum logic [2:0] {
		idle,
		lookup,
		write_back,
		fill,
		respond,
		flush_scan,
		flush_write
	} ctrl_state_t;

endpackage

/* source/mem_pkg.sv */
package mem_pkg;

	// Line address is tag and index together
	typedef logic [24:0] line_addr_t;

	// One line transfer to or from main memory
	// start is a single-cycle strobe, wline only matters on writes
	typedef struct packed {
		logic              start;
		logic              write;
		line_addr_t        line_addr;
		cache_pkg::line_t  wline;
	} mem_req_t;

endpackage

/* source/cache_tag_store.sv */
`timescale 1ns/1ps

module cache_tag_store (
	input  logic               clk,
	input  logic               rst,
	input  cache_pkg::index_t  index,
	input  cache_pkg::tag_t    tag,
	input  logic               touch,
	input  logic               install,
	input  logic               mark_dirty,
	input  logic               invalidate_all,
	input  logic               way,
	input  cache_pkg::index_t  scan_index,
	input  logic               scan_way,
	output logic               hit,
	output logic               hit_way,
	output logic               victim_way,
	output logic               victim_dirty,
	output cache_pkg::tag_t    victim_tag,
	output logic               scan_dirty,
	output cache_pkg::tag_t    scan_tag
);

	// Per-way state, one entry per set
	cache_pkg::tag_t              tags  [cache_pkg::ways][cache_pkg::sets];
	logic [cache_pkg::sets-1:0]   valid [cache_pkg::ways];
	logic [cache_pkg::sets-1:0]   dirty [cache_pkg::ways];
	// LRU bit names the way to replace next
	logic [cache_pkg::sets-1:0]   lru;
	logic [cache_pkg::ways-1:0]   match;

	// ----------------------------------------------------------------------
	// Lookup and victim choice
	// ----------------------------------------------------------------------

	always_comb begin
		for (int w = 0; w < cache_pkg::ways; w++) begin
			match[w] = valid[w][index] && (tags[w][index] == tag);
		end
	end

	assign hit     = |match;
	assign hit_way = match[1];

	// Empty way first, LRU way only when the set is full
	assign victim_way   = !valid[0][index] ? 1'b0 :
	                      !valid[1][index] ? 1'b1 : lru[index];
	assign victim_dirty = valid[victim_way][index] && dirty[victim_way][index];
	assign victim_tag   = tags[victim_way][index];

	// Flush walk view of one slot
	assign scan_dirty = valid[scan_way][scan_index] && dirty[scan_way][scan_index];
	assign scan_tag   = tags[scan_way][scan_index];

	// ----------------------------------------------------------------------
	// Updates
	// ----------------------------------------------------------------------

	always_ff @(posedge clk) begin
		if (rst) begin
			valid <= '{default: '0};
			dirty <= '{default: '0};
			lru   <= '0;
		end else begin
			if (invalidate_all) begin
				valid <= '{default: '0};
				dirty <= '{default: '0};
			end else if (install) begin
				tags[way][index]  <= tag;
				valid[way][index] <= 1'b1;
				// Write miss installs the line already dirty
				dirty[way][index] <= mark_dirty;
			end else if (mark_dirty) begin
				dirty[way][index] <= 1'b1;
			end
			// Point away from the way just used
			if (touch)
				lru[index] <= ~way;
		end
	end

endmodule

/* source/cache_data_store.sv */
`timescale 1ns/1ps

module cache_data_store (
	input  logic               clk,
	input  cache_pkg::index_t  index,
	input  logic               way,
	input  logic               fill_en,
	input  cache_pkg::line_t   fill_line,
	input  logic               word_en,
	input  cache_pkg::offset_t offset,
	input  cache_pkg::word_t   wdata,
	output cache_pkg::line_t   line
);

	// Line storage, one array per way
	cache_pkg::line_t lines [cache_pkg::ways][cache_pkg::sets];
	cache_pkg::line_t next_line;

	// Addressed line, used for read hits and write-back
	assign line = lines[way][index];

	// Fill replaces the line, a word write merges on top of it
	always_comb begin
		next_line = fill_en ? fill_line : line;
		if (word_en)
			next_line[offset] = wdata;
	end

	always_ff @(posedge clk) begin
		if (fill_en || word_en)
			lines[way][index] <= next_line;
	end

endmodule

/* source/cache_controller.sv */
`timescale 1ns/1ps

module cache_controller (
	input  logic                clk,
	input  logic                rst,
	input  cache_pkg::cpu_req_t req,
	// Tag store results
	input  logic                hit,
	input  logic                hit_way,
	input  logic                victim_way,
	input  logic                victim_dirty,
	input  cache_pkg::tag_t     victim_tag,
	input  logic                scan_dirty,
	input  cache_pkg::tag_t     scan_tag,
	// Data store and memory returns
	input  cache_pkg::line_t    line,
	input  logic                mem_done,
	input  cache_pkg::line_t    rline,
	output logic                ready,
	output cache_pkg::word_t    rdata,
	// Tag store commands
	output cache_pkg::index_t   index,
	output cache_pkg::tag_t     tag,
	output logic                way,
	output logic                touch,
	output logic                install,
	output logic                mark_dirty,
	output logic                invalidate_all,
	output cache_pkg::index_t   scan_index,
	output logic                scan_way,
	// Data store controls
	output cache_pkg::index_t   line_index,
	output logic                line_way,
	output logic                fill_en,
	output cache_pkg::line_t    fill_line,
	output logic                word_en,
	output cache_pkg::offset_t  offset,
	output cache_pkg::word_t    wdata,
	output mem_pkg::mem_req_t   mem_req
);

	localparam int slot_w = $clog2(cache_pkg::sets * cache_pkg::ways);

	cache_pkg::ctrl_state_t state;
	cache_pkg::cpu_req_t    req_r;
	logic                   way_r;
	logic [slot_w-1:0]      slot;
	logic                   flushing;
	logic                   hit_now;
	logic                   fill_now;
	logic                   flush_end;

	// ----------------------------------------------------------------------
	// Address fields and store addressing
	// ----------------------------------------------------------------------

	assign offset = req_r.addr[2:0];
	assign index  = req_r.addr[6:3];
	assign tag    = req_r.addr[27:7];
	assign wdata  = req_r.wdata;

	// Flush slot counter, set in the high bits, way in bit 0
	assign scan_index = slot[slot_w-1:1];
	assign scan_way   = slot[0];

	// Lookup steers straight from the tag store, later states use way_r
	assign way = (state == cache_pkg::lookup) ? (hit ? hit_way : victim_way) : way_r;

	assign flushing   = (state == cache_pkg::flush_scan) || (state == cache_pkg::flush_write);
	assign line_index = flushing ? scan_index : index;
	assign line_way   = flushing ? scan_way : way;

	// ----------------------------------------------------------------------
	// Single-cycle commands
	// ----------------------------------------------------------------------

	assign hit_now  = (state == cache_pkg::lookup) && hit;
	assign fill_now = (state == cache_pkg::fill) && mem_done;

	assign touch      = hit_now || fill_now;
	assign install    = fill_now;
	assign mark_dirty = req_r.write && (hit_now || fill_now);

	// Write word lands on a hit line or merges into the filled line
	assign word_en    = mark_dirty;
	assign fill_en    = fill_now;
	assign fill_line  = rline;

	// Last slot clean, or its write-back just finished
	assign flush_end = (&slot) &&
	                   (((state == cache_pkg::flush_scan) && !scan_dirty) ||
	                    ((state == cache_pkg::flush_write) && mem_done));
	assign invalidate_all = flush_end;

	// ----------------------------------------------------------------------
	// FSM
	// ----------------------------------------------------------------------

	always_ff @(posedge clk) begin
		if (rst) begin
			state         <= cache_pkg::idle;
			ready         <= 1'b0;
			mem_req.start <= 1'b0;
			slot          <= '0;
		end else begin
			ready         <= 1'b0;
			mem_req.start <= 1'b0;
			case (state)
				cache_pkg::idle: begin
					// Skip the ready cycle so a held request is not taken twice
					if (!ready && req.valid) begin
						req_r <= req;
						slot  <= '0;
						state <= req.flush ? cache_pkg::flush_scan : cache_pkg::lookup;
					end
				end
				cache_pkg::lookup: begin
					way_r <= hit ? hit_way : victim_way;
					if (hit) begin
						state <= cache_pkg::respond;
					end else begin
						// Dirty victim goes out first, else fetch right away
						mem_req.start     <= 1'b1;
						mem_req.write     <= victim_dirty;
						mem_req.line_addr <= victim_dirty ? {victim_tag, index} : {tag, index};
						mem_req.wline     <= line;
						state <= victim_dirty ? cache_pkg::write_back : cache_pkg::fill;
					end
				end
				cache_pkg::write_back: begin
					if (mem_done) begin
						mem_req.start     <= 1'b1;
						mem_req.write     <= 1'b0;
						mem_req.line_addr <= {tag, index};
						state             <= cache_pkg::fill;
					end
				end
				cache_pkg::fill: begin
					// Install and merge happen on the done cycle
					if (mem_done)
						state <= cache_pkg::respond;
				end
				cache_pkg::respond: begin
					ready <= 1'b1;
					rdata <= line[offset];
					state <= cache_pkg::idle;
				end
				cache_pkg::flush_scan: begin
					if (scan_dirty) begin
						mem_req.start     <= 1'b1;
						mem_req.write     <= 1'b1;
						mem_req.line_addr <= {scan_tag, scan_index};
						mem_req.wline     <= line;
						state             <= cache_pkg::flush_write;
					end else if (flush_end) begin
						state <= cache_pkg::respond;
					end else begin
						slot <= slot + 1'b1;
					end
				end
				cache_pkg::flush_write: begin
					if (mem_done) begin
						slot  <= slot + 1'b1;
						state <= flush_end ? cache_pkg::respond : cache_pkg::flush_scan;
					end
				end
				default: state <= cache_pkg::idle;
			endcase
		end
	end

endmodule

/* source/main_memory.sv */
`timescale 1ns/1ps

module main_memory #(
	parameter int MEM_ADDR_W  = 9,
	parameter int MEM_LATENCY = 4
) (
	input  logic              clk,
	input  logic              rst,
	input  mem_pkg::mem_req_t req,
	output logic              done,
	output cache_pkg::line_t  rline
);

	localparam int cnt_w = $clog2(MEM_LATENCY + 1);

	// Only the low line address bits are stored, higher ones alias
	cache_pkg::line_t        lines [2**MEM_ADDR_W];
	logic [MEM_ADDR_W-1:0]   addr_r;
	logic [cnt_w-1:0]        count;

	// Each word starts out holding its own word address
	initial begin
		for (int i = 0; i < 2**MEM_ADDR_W; i++) begin
			for (int w = 0; w < cache_pkg::line_words; w++) begin
				lines[i][w] = cache_pkg::word_t'(i * cache_pkg::line_words + w);
			end
		end
	end

	// Writes land on the start edge
	always @(posedge clk) begin
		if (req.start) begin
			addr_r <= req.line_addr[MEM_ADDR_W-1:0];
			if (req.write)
				lines[req.line_addr[MEM_ADDR_W-1:0]] <= req.wline;
		end
	end

	// ----------------------------------------------------------------------
	// Latency counter, done when it reaches one
	// ----------------------------------------------------------------------

	always_ff @(posedge clk) begin
		if (rst)
			count <= '0;
		else if (req.start)
			count <= cnt_w'(MEM_LATENCY);
		else if (count != '0)
			count <= count - 1'b1;
	end

	assign done  = (count == cnt_w'(1));
	assign rline = lines[addr_r];

endmodule

/* source/cache_top.sv */
`timescale 1ns/1ps

module cache_top #(
	parameter int MEM_ADDR_W  = 9,
	parameter int MEM_LATENCY = 4
) (
	input  logic              clk,
	input  logic              rst,
	input  logic              valid,
	input  logic              write,
	input  logic              flush,
	input  cache_pkg::addr_t  addr,
	input  cache_pkg::word_t  wdata,
	output cache_pkg::word_t  rdata,
	output logic              ready
);

	cache_pkg::cpu_req_t req;
	mem_pkg::mem_req_t   mem_req;
	cache_pkg::index_t   index, scan_index, line_index;
	cache_pkg::tag_t     tag, victim_tag, scan_tag;
	cache_pkg::offset_t  offset;
	cache_pkg::word_t    store_wdata;
	cache_pkg::line_t    line, fill_line, rline;
	logic                way, scan_way, line_way;
	logic                touch, install, mark_dirty, invalidate_all;
	logic                hit, hit_way, victim_way, victim_dirty, scan_dirty;
	logic                fill_en, word_en, mem_done;

	// Processor port bundled for the controller
	assign req.valid = valid;
	assign req.write = write;
	assign req.flush = flush;
	assign req.addr  = addr;
	assign req.wdata = wdata;

	cache_controller cache_controller_i (
		.clk, .rst, .req, .hit, .hit_way, .victim_way, .victim_dirty, .victim_tag,
		.scan_dirty, .scan_tag, .line, .mem_done, .rline, .ready, .rdata,
		.index, .tag, .way, .touch, .install, .mark_dirty, .invalidate_all,
		.scan_index, .scan_way, .line_index, .line_way, .fill_en, .fill_line,
		.word_en, .offset, .wdata(store_wdata), .mem_req
	);

	cache_tag_store cache_tag_store_i (
		.clk, .rst, .index, .tag, .touch, .install, .mark_dirty, .invalidate_all,
		.way, .scan_index, .scan_way, .hit, .hit_way, .victim_way, .victim_dirty,
		.victim_tag, .scan_dirty, .scan_tag
	);

	cache_data_store cache_data_store_i (
		.clk, .index(line_index), .way(line_way), .fill_en, .fill_line,
		.word_en, .offset, .wdata(store_wdata), .line
	);

	main_memory #(
		.MEM_ADDR_W  (MEM_ADDR_W),
		.MEM_LATENCY (MEM_LATENCY)
	) main_memory_i (
		.clk, .rst, .req(mem_req), .done(mem_done), .rline
	);

endmodule

/* sim/cache_tb.sv */
`timescale 1ns/1ps

module cache_tb;

	localparam int max_entries    = 64;
	localparam int timeout_cycles = 200;
	// Memory model keeps 2^9 lines, so 12 word address bits are unique
	localparam int ref_words      = 4096;

	// One request and its expected read data
	typedef struct packed {
		logic             write;
		logic             flush;
		cache_pkg::addr_t addr;
		cache_pkg::word_t wdata;
		cache_pkg::word_t expected;
	} entry_t;

	logic             clk;
	logic             rst;
	logic             valid;
	logic             write;
	logic             flush;
	cache_pkg::addr_t addr;
	cache_pkg::word_t wdata;
	cache_pkg::word_t rdata;
	logic             ready;

	entry_t           stim [max_entries];
	int               n_entries;
	logic [31:0]      ref_mem [ref_words];
	logic [31:0]      lfsr;

	cache_top #(
		.MEM_ADDR_W  (9),
		.MEM_LATENCY (4)
	) cache_top_i (
		.clk, .rst, .valid, .write, .flush, .addr, .wdata, .rdata, .ready
	);

	// 8 ns clock
	initial clk = 1'b0;
	always #4 clk = ~clk;

	// ----------------------------------------------------------------------
	// Helpers
	// ----------------------------------------------------------------------

	// Taps for x^32 + x^22 + x^2 + x + 1 with the new bit entering at bit 0
	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	// One LFSR step per bit taken
	task automatic random_word(output logic [31:0] value);
		value = '0;
		for (int b = 0; b < 32; b++) begin
			lfsr  = lfsr_step(lfsr);
			value = {value[30:0], lfsr[0]};
		end
	endtask

	task automatic add_entry(input logic wr, input logic fl, input cache_pkg::addr_t a,
			input cache_pkg::word_t d);
		stim[n_entries] = '{write: wr, flush: fl, addr: a, wdata: d, expected: '0};
		n_entries++;
	endtask

	task automatic check_value(input string name, input logic [31:0] expected,
			input logic [31:0] actual);
		if (actual !== expected) begin
			$display("[FAIL] %s expected 0x%08h actual 0x%08h", name, expected, actual);
			$display("Finished with errors");
			$fatal(1, "value mismatch on %s", name);
		end
	endtask

	// ----------------------------------------------------------------------
	// Stimulus
	// ----------------------------------------------------------------------

	initial begin
		cache_pkg::word_t w;
		logic [11:0]      a;
		int               cycles;
		logic             got;

		rst       = 1'b1;
		valid     = 1'b0;
		write     = 1'b0;
		flush     = 1'b0;
		addr      = '0;
		wdata     = '0;
		lfsr      = 32'h0b76_7187;
		n_entries = 0;

		// Read misses on two tags in set 0 that alias in memory
		for (int i = 0; i < 8; i++)
			add_entry(1'b0, 1'b0, 28'h000_0000 + i, '0);
		for (int i = 0; i < 8; i++)
			add_entry(1'b0, 1'b0, 28'h200_0000 + i, '0);

		// Two dirty lines sharing set 3 with one per way
		random_word(w);
		add_entry(1'b1, 1'b0, 28'h000_1018, w);
		random_word(w);
		add_entry(1'b1, 1'b0, 28'h200_1418, w);
		add_entry(1'b0, 1'b0, 28'h000_1018, '0);
		add_entry(1'b0, 1'b0, 28'h200_1418, '0);

		// Two more tags in set 3 push both dirty lines out
		add_entry(1'b0, 1'b0, 28'h000_1818, '0);
		add_entry(1'b0, 1'b0, 28'h200_1c18, '0);
		add_entry(1'b0, 1'b0, 28'h000_1018, '0);
		add_entry(1'b0, 1'b0, 28'h200_1418, '0);

		// Flush and then read the written words back from memory
		random_word(w);
		add_entry(1'b1, 1'b0, 28'h000_0234, w);
		random_word(w);
		add_entry(1'b1, 1'b0, 28'h200_03a0, w);
		add_entry(1'b0, 1'b1, '0, '0);
		add_entry(1'b0, 1'b0, 28'h000_0234, '0);
		add_entry(1'b0, 1'b0, 28'h200_03a0, '0);
		// Aliased tags in the same sets see the same memory words
		add_entry(1'b0, 1'b0, 28'h200_0234, '0);
		add_entry(1'b0, 1'b0, 28'h000_03a0, '0);

		// Write miss on offset 3 leaves the other seven words as in memory
		random_word(w);
		add_entry(1'b1, 1'b0, 28'h300_0563, w);
		for (int i = 0; i < 8; i++)
			add_entry(1'b0, 1'b0, 28'h300_0560 + i, '0);

		// Reference memory aliased on the low 12 address bits
		for (int i = 0; i < ref_words; i++)
			ref_mem[i] = i;
		for (int i = 0; i < n_entries; i++) begin
			a = stim[i].addr[11:0];
			if (stim[i].flush)
				continue;
			if (stim[i].write)
				ref_mem[a] = stim[i].wdata;
			else
				stim[i].expected = ref_mem[a];
		end

		repeat (3) @(posedge clk);
		#1 rst = 1'b0;

		for (int i = 0; i < n_entries; i++) begin
			@(posedge clk);
			#1;
			valid = 1'b1;
			write = stim[i].write;
			flush = stim[i].flush;
			addr  = stim[i].addr;
			wdata = stim[i].wdata;

			// Request held until ready shows up
			cycles = 0;
			got    = 1'b0;
			while (!got && cycles < timeout_cycles) begin
				@(posedge clk);
				#1;
				cycles++;
				got = ready;
			end
			if (!got) begin
				$display("ready never came for request %0d at address 0x%07h", i,
					stim[i].addr);
				$display("Finished with errors");
				$fatal(1, "request timed out");
			end

			if (!stim[i].write && !stim[i].flush)
				check_value("rdata", stim[i].expected, rdata);
			valid = 1'b0;
		end

		$display("Finished with no errors");
		$finish;
	end

endmodule

/* verilog.f */
source/cache_pkg.sv
source/mem_pkg.sv
source/cache_tag_store.sv
source/cache_data_store.sv
source/cache_controller.sv
source/main_memory.sv
source/cache_top.sv
sim/cache_tb.sv
